//--- verilog/noc_pkg.sv
// Shared types of the mesh NoC injection endpoint
// Endpoint IDs, addresses, SAM rules, flits and port directions
// for a 4x4 mesh with dimension-ordered XY routing

package noc_pkg;

  // One mesh coordinate, enough for a 4x4 mesh
  typedef logic [1:0] noc_coord_t;

  // Endpoint ID as a pair of mesh coordinates
  typedef struct packed {
    noc_coord_t x;
    noc_coord_t y;
  } noc_id_t;

  // Byte address of a request
  typedef logic [31:0] noc_addr_t;

  // Payload carried by a single flit
  typedef logic [31:0] noc_data_t;

  // One range of the system address map
  // Matches when start_addr <= addr < end_addr
  typedef struct packed {
    noc_id_t   id;
    noc_addr_t start_addr;
    noc_addr_t end_addr;
  } noc_addr_rule_t;

  // Single-flit packet
  typedef struct packed {
    noc_id_t   dst;
    noc_id_t   src;
    noc_data_t payload;
  } noc_flit_t;

  // Address translation mode
  typedef enum logic [0:0] {
    SamDecode = 1'b0,
    XyOffset  = 1'b1
  } noc_route_algo_e;

  // Output port index of the router
  typedef enum logic [2:0] {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } noc_dir_e;

  // Number of output ports
  localparam int unsigned NumDirs = 5;

  // One valid bit per output port, indexed by noc_dir_e
  typedef logic [NumDirs-1:0] noc_port_valid_t;

endpackage

//--- verilog/noc_addr_decode.sv
// System address map decoder
// Matches a byte address against a table of ranges and returns the
// endpoint ID of the matching range, or a miss when none matches

module noc_addr_decode #(
  // Number of rules in the address map
  parameter int unsigned NumRules = 1,
  // Address map, one rule per range
  parameter noc_pkg::noc_addr_rule_t [NumRules-1:0] SamRules = '0
) (
  input  noc_pkg::noc_addr_t addr_i,
  output noc_pkg::noc_id_t   id_o,
  output logic               miss_o
);

  import noc_pkg::*;

  // Result of the rule scan
  noc_id_t match_id;
  logic    match_found;

  // Scan all rules in order
  // A later match overrides an earlier one, so the last match wins
  always_comb begin
    match_id    = '0;
    match_found = 1'b0;
    for (int unsigned i = 0; i < NumRules; i++) begin
      // Half-open range check
      if ((addr_i >= SamRules[i].start_addr) &&
          (addr_i < SamRules[i].end_addr)) begin
        match_id    = SamRules[i].id;
        match_found = 1'b1;
      end
    end
  end

  // ID stays zero on a miss
  assign id_o   = match_id;
  assign miss_o = ~match_found;

endmodule

//--- verilog/noc_id_translation.sv
// Address to endpoint ID translation
// Uses either the system address map decoder or fixed coordinate
// bit fields of the address, selected by RouteAlgo

module noc_id_translation #(
  // Translation mode
  parameter noc_pkg::noc_route_algo_e RouteAlgo = noc_pkg::SamDecode,
  // Number of address map rules
  parameter int unsigned NumRules = 1,
  // System address map
  parameter noc_pkg::noc_addr_rule_t [NumRules-1:0] SamRules = '0,
  // Lowest address bit of the X coordinate in offset mode
  parameter int unsigned XAddrOffset = 12,
  // Lowest address bit of the Y coordinate in offset mode
  parameter int unsigned YAddrOffset = 14
) (
  input  noc_pkg::noc_addr_t addr_i,
  output noc_pkg::noc_id_t   id_o,
  output logic               miss_o
);

  import noc_pkg::*;

  if (RouteAlgo == SamDecode) begin : gen_sam_decode
    // Range lookup in the address map
    noc_addr_decode #(
      .NumRules ( NumRules ),
      .SamRules ( SamRules )
    ) i_addr_decode (
      .addr_i ( addr_i ),
      .id_o   ( id_o   ),
      .miss_o ( miss_o )
    );
  end else if (RouteAlgo == XyOffset) begin : gen_xy_offset
    // Coordinates sit at fixed bit positions
    assign id_o.x = addr_i[XAddrOffset +: $bits(noc_coord_t)];
    assign id_o.y = addr_i[YAddrOffset +: $bits(noc_coord_t)];
    // Every address maps to some endpoint here
    assign miss_o = 1'b0;
  end else begin : gen_bad_algo
    $fatal(1, "Unsupported address translation mode %0d", RouteAlgo);
  end

endmodule

//--- verilog/noc_flit_packer.sv
// Flit packer
// Registers a request into a single flit with destination, own
// coordinates as source, and payload
// A decode miss raises the error strobe instead of the valid

module noc_flit_packer #(
  // X coordinate of this endpoint
  parameter noc_pkg::noc_coord_t LocalX = '0,
  // Y coordinate of this endpoint
  parameter noc_pkg::noc_coord_t LocalY = '0
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                valid_i,
  input  noc_pkg::noc_id_t    dst_i,
  input  logic                miss_i,
  input  noc_pkg::noc_data_t  data_i,
  output logic                valid_o,
  output noc_pkg::noc_flit_t  flit_o,
  output logic                error_o
);

  import noc_pkg::*;

  // Flit built from the current request
  noc_flit_t flit_d;

  always_comb begin
    flit_d         = '0;
    flit_d.dst     = dst_i;
    flit_d.src.x   = LocalX;
    flit_d.src.y   = LocalY;
    flit_d.payload = data_i;
  end

  // Strobes, split on the decode result
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
      error_o <= 1'b0;
    end else begin
      valid_o <= valid_i & ~miss_i;
      error_o <= valid_i & miss_i;
    end
  end

  // Payload register, loaded on every request
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      flit_o <= flit_d;
    end
  end

endmodule

//--- verilog/noc_xy_route.sv
// XY router output stage
// Picks the output port of a flit by dimension-ordered routing,
// X first and then Y, and registers a one-hot port valid,
// the flit and the decode error strobe

module noc_xy_route #(
  // X coordinate of this endpoint
  parameter noc_pkg::noc_coord_t LocalX = '0,
  // Y coordinate of this endpoint
  parameter noc_pkg::noc_coord_t LocalY = '0
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     valid_i,
  input  noc_pkg::noc_flit_t       flit_i,
  input  logic                     error_i,
  output noc_pkg::noc_port_valid_t port_valid_o,
  output noc_pkg::noc_flit_t       flit_o,
  output logic                     error_o
);

  import noc_pkg::*;

  // Chosen direction and its one-hot valid
  noc_dir_e        route_dir;
  noc_port_valid_t port_valid_d;

  // Dimension-ordered routing decision
  always_comb begin
    if (flit_i.dst.x > LocalX) begin
      route_dir = East;
    end else if (flit_i.dst.x < LocalX) begin
      route_dir = West;
    end else if (flit_i.dst.y > LocalY) begin
      // Same column, move along Y
      route_dir = North;
    end else if (flit_i.dst.y < LocalY) begin
      route_dir = South;
    end else begin
      // Flit is addressed to this endpoint
      route_dir = Local;
    end
  end

  // Only one port sees the valid
  always_comb begin
    port_valid_d = '0;
    if (valid_i) begin
      port_valid_d[route_dir] = 1'b1;
    end
  end

  // Control outputs
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      port_valid_o <= '0;
      error_o      <= 1'b0;
    end else begin
      port_valid_o <= port_valid_d;
      error_o      <= error_i;
    end
  end

  // Flit is shared by all ports
  always_ff @(posedge clk_i) begin
    if (valid_i || error_i) begin
      flit_o <= flit_i;
    end
  end

endmodule

//--- verilog/noc_inject_top.sv
// Injection side of a mesh NoC endpoint
// Translates a request address to a destination ID, packs the flit
// and selects the XY output port, two cycles from request to port

module noc_inject_top #(
  // Translation mode
  parameter noc_pkg::noc_route_algo_e RouteAlgo = noc_pkg::SamDecode,
  // Number of address map rules
  parameter int unsigned NumRules = 1,
  // System address map
  parameter noc_pkg::noc_addr_rule_t [NumRules-1:0] SamRules = '0,
  // Coordinate bit positions for offset mode
  parameter int unsigned XAddrOffset = 12,
  parameter int unsigned YAddrOffset = 14,
  // Coordinates of this endpoint
  parameter noc_pkg::noc_coord_t LocalX = '0,
  parameter noc_pkg::noc_coord_t LocalY = '0
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     req_valid_i,
  input  noc_pkg::noc_addr_t       req_addr_i,
  input  noc_pkg::noc_data_t       req_data_i,
  output noc_pkg::noc_port_valid_t port_valid_o,
  output noc_pkg::noc_flit_t       port_flit_o,
  output logic                     dec_error_o
);

  import noc_pkg::*;

  // Translation result, same cycle as the request
  noc_id_t   dst_id;
  logic      dec_miss;

  // Packer stage outputs
  logic      pack_valid;
  noc_flit_t pack_flit;
  logic      pack_error;

  noc_id_translation #(
    .RouteAlgo   ( RouteAlgo   ),
    .NumRules    ( NumRules    ),
    .SamRules    ( SamRules    ),
    .XAddrOffset ( XAddrOffset ),
    .YAddrOffset ( YAddrOffset )
  ) i_id_translation (
    .addr_i ( req_addr_i ),
    .id_o   ( dst_id     ),
    .miss_o ( dec_miss   )
  );

  // First register stage
  noc_flit_packer #(
    .LocalX ( LocalX ),
    .LocalY ( LocalY )
  ) i_flit_packer (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .valid_i ( req_valid_i ),
    .dst_i   ( dst_id      ),
    .miss_i  ( dec_miss    ),
    .data_i  ( req_data_i  ),
    .valid_o ( pack_valid  ),
    .flit_o  ( pack_flit   ),
    .error_o ( pack_error  )
  );

  // Second register stage
  noc_xy_route #(
    .LocalX ( LocalX ),
    .LocalY ( LocalY )
  ) i_xy_route (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .valid_i      ( pack_valid   ),
    .flit_i       ( pack_flit    ),
    .error_i      ( pack_error   ),
    .port_valid_o ( port_valid_o ),
    .flit_o       ( port_flit_o  ),
    .error_o      ( dec_error_o  )
  );

endmodule

//--- test/tb_noc_inject_top.sv
// Testbench for the NoC injection endpoint
// Applies a table of requests and a random burst, predicts the
// translated destination and XY output port with its own model,
// and checks every output exactly two cycles after each strobe

module tb_noc_inject_top #(
  parameter bit UseSam = 1'b1
);

  timeunit 1ns;
  timeprecision 1ps;

  import noc_pkg::*;

  // Endpoint under test sits at (1,2)
  localparam noc_coord_t LocalX = 2'd1;
  localparam noc_coord_t LocalY = 2'd2;
  localparam int NumRules = 4;
  localparam int XOffset = 12;
  localparam int YOffset = 14;
  localparam int NumStim = 14;
  localparam int NumRandom = 64;
  localparam int ResetTimeout = 10;
  localparam int DrainTimeout = 10;

  // Address map with a gap at 0x2000..0x2fff and nothing from 0x5000 up
  // Rule id is {x, y}
  localparam noc_addr_rule_t [NumRules-1:0] SamMap = {
    {4'h3, 32'h0000_4000, 32'h0000_5000},  // (0,3) lies West
    {4'hd, 32'h0000_3000, 32'h0000_4000},  // (3,1) lies East
    {4'h7, 32'h0000_1000, 32'h0000_2000},  // (1,3) lies North
    {4'h6, 32'h0000_0000, 32'h0000_1000}   // (1,2) is Local
  };

  localparam noc_route_algo_e Algo = noc_route_algo_e'(UseSam ? SamDecode : XyOffset);

  // One stimulus row
  typedef struct packed {
    noc_addr_t addr;
    noc_data_t data;
  } stim_t;

  // Result of the model translation
  typedef struct packed {
    logic    miss;
    noc_id_t id;
  } xlate_t;

  // Expected outputs for one request slot
  typedef struct packed {
    logic            req;
    logic            error;
    noc_port_valid_t ports;
    noc_flit_t       flit;
  } exp_t;

  // Comments give the SAM result first, then the offset-mode result
  localparam stim_t StimTable [NumStim] = '{
    '{32'h0000_0010, 32'hcafe_0001},  // Local, offset (0,0) West
    '{32'h0000_1800, 32'hcafe_0002},  // North, offset (1,0) South
    '{32'h0000_2400, 32'hcafe_0003},  // gap miss, offset (2,0) East
    '{32'h0000_3004, 32'hcafe_0004},  // East, offset (3,0) East
    '{32'h0000_4ffc, 32'hcafe_0005},  // West at top of rule, offset (0,1)
    '{32'h0000_5000, 32'hcafe_0006},  // miss at end bound, offset (1,1) South
    '{32'h0000_9000, 32'hcafe_0007},  // miss, offset (1,2) Local
    '{32'h0000_d000, 32'hcafe_0008},  // miss, offset (1,3) North
    '{32'h0000_0fff, 32'hcafe_0009},  // Local at top of rule
    '{32'h0000_1000, 32'hcafe_000a},  // North at start bound
    '{32'h0000_2fff, 32'hcafe_000b},  // last gap address
    '{32'hffff_f000, 32'hcafe_000c},  // far above all rules, offset (3,3)
    '{32'h0000_e000, 32'hcafe_000d},  // miss, offset (2,3) East
    '{32'h0000_c000, 32'hcafe_000e}   // miss, offset (0,3) West
  };

  logic            clk_i;
  logic            reset_i;
  logic            req_valid_i;
  noc_addr_t       req_addr_i;
  noc_data_t       req_data_i;
  noc_port_valid_t port_valid_o;
  noc_flit_t       port_flit_o;
  logic            dec_error_o;

  // Expected results, oldest first, one entry per driven cycle
  exp_t        exp_q[$];
  logic [31:0] lcg_state;

  noc_inject_top #(
    .RouteAlgo   ( Algo     ),
    .NumRules    ( NumRules ),
    .SamRules    ( SamMap   ),
    .XAddrOffset ( XOffset  ),
    .YAddrOffset ( YOffset  ),
    .LocalX      ( LocalX   ),
    .LocalY      ( LocalY   )
  ) uut (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .req_valid_i  ( req_valid_i  ),
    .req_addr_i   ( req_addr_i   ),
    .req_data_i   ( req_data_i   ),
    .port_valid_o ( port_valid_o ),
    .port_flit_o  ( port_flit_o  ),
    .dec_error_o  ( dec_error_o  )
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // Reset covers the first two rising edges
  initial begin
    reset_i = 1'b1;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Address map lookup, last matching rule wins
  function automatic xlate_t translate_addr(input noc_addr_t addr);
    xlate_t t;
    logic   found;
    t     = '0;
    found = 1'b0;
    if (UseSam) begin
      t.miss = 1'b1;
      // Walk backwards so the first hit is the last rule in order
      for (int i = NumRules - 1; i >= 0; i--) begin
        if (!found && addr >= SamMap[i].start_addr && addr < SamMap[i].end_addr) begin
          t.id   = SamMap[i].id;
          t.miss = 1'b0;
          found  = 1'b1;
        end
      end
    end else begin
      t.id.x = noc_coord_t'((addr >> XOffset) & 32'h3);
      t.id.y = noc_coord_t'((addr >> YOffset) & 32'h3);
    end
    return t;
  endfunction

  // X offset is resolved before Y
  function automatic noc_port_valid_t route_ports(input noc_id_t dst);
    noc_port_valid_t p;
    int              dx;
    int              dy;
    p  = '0;
    dx = int'(dst.x) - int'(LocalX);
    dy = int'(dst.y) - int'(LocalY);
    if (dx > 0) p[East] = 1'b1;
    else if (dx < 0) p[West] = 1'b1;
    else if (dy > 0) p[North] = 1'b1;
    else if (dy < 0) p[South] = 1'b1;
    else p[Local] = 1'b1;
    return p;
  endfunction

  function automatic exp_t expect_of(input logic valid, input noc_addr_t addr,
                                     input noc_data_t data);
    exp_t   e;
    xlate_t t;
    e     = '0;
    t     = translate_addr(addr);
    e.req = valid;
    if (valid) begin
      if (t.miss) e.error = 1'b1;
      else e.ports = route_ports(t.id);
      e.flit.dst     = t.id;
      e.flit.src.x   = LocalX;
      e.flit.src.y   = LocalY;
      e.flit.payload = data;
    end
    return e;
  endfunction

  task automatic check_outputs(input exp_t e);
    assert (port_valid_o == e.ports) else
      report_error($sformatf("Mismatch port_valid_o got 0x%h expected 0x%h",
                             port_valid_o, e.ports));
    assert (dec_error_o == e.error) else
      report_error($sformatf("Mismatch dec_error_o got 0x%h expected 0x%h",
                             dec_error_o, e.error));
    // Flit only matters when a port takes it
    if (e.ports != '0) begin
      assert (port_flit_o.dst == e.flit.dst) else
        report_error($sformatf("Mismatch port_flit_o.dst got 0x%h expected 0x%h",
                               port_flit_o.dst, e.flit.dst));
      assert (port_flit_o.src == e.flit.src) else
        report_error($sformatf("Mismatch port_flit_o.src got 0x%h expected 0x%h",
                               port_flit_o.src, e.flit.src));
      assert (port_flit_o.payload == e.flit.payload) else
        report_error($sformatf("Mismatch port_flit_o.payload got 0x%h expected 0x%h",
                               port_flit_o.payload, e.flit.payload));
    end
  endtask

  // Drive one cycle, then check the slot driven two edges earlier
  task automatic drive_cycle(input logic valid, input noc_addr_t addr,
                             input noc_data_t data);
    exp_t head;
    @(posedge clk_i);
    req_valid_i <= valid;
    req_addr_i  <= addr;
    req_data_i  <= data;
    exp_q.push_back(expect_of(valid, addr, data));
    @(negedge clk_i);
    if (exp_q.size() > 2) begin
      head = exp_q.pop_front();
      check_outputs(head);
    end
  endtask

  function automatic int pending_requests();
    int n;
    n = 0;
    foreach (exp_q[i]) begin
      if (exp_q[i].req) n++;
    end
    return n;
  endfunction

  initial begin
    int        wait_cycles;
    logic      rnd_valid;
    noc_addr_t rnd_addr;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_data_i  = '0;
    lcg_state   = 32'd93691;

    wait_cycles = 0;
    while (reset_i !== 1'b0) begin
      if (wait_cycles >= ResetTimeout) report_error("Reset was not released in time");
      @(posedge clk_i);
      wait_cycles++;
    end

    // Quiet outputs with no requests
    repeat (4) drive_cycle(1'b0, '0, '0);

    foreach (StimTable[i]) begin
      drive_cycle(1'b1, StimTable[i].addr, StimTable[i].data);
    end

    // Mostly back to back, with a few idle slots
    for (int n = 0; n < NumRandom; n++) begin
      lcg_state = lcg_next(lcg_state);
      rnd_valid = (lcg_state[14:12] != 3'b000);
      rnd_addr  = {16'h0000, lcg_state[31:16]};
      // Half of the addresses land at or below the SAM rules
      if (lcg_state[15]) rnd_addr = rnd_addr & 32'h0000_4fff;
      lcg_state = lcg_next(lcg_state);
      drive_cycle(rnd_valid, rnd_addr, lcg_state);
    end

    wait_cycles = 0;
    while (pending_requests() > 0) begin
      if (wait_cycles >= DrainTimeout) report_error("Pipeline did not drain in time");
      drive_cycle(1'b0, '0, '0);
      wait_cycles++;
    end

    $display("all tests passed");
    $finish;
  end

endmodule

//--- project.f
verilog/noc_pkg.sv
verilog/noc_addr_decode.sv
verilog/noc_id_translation.sv
verilog/noc_flit_packer.sv
verilog/noc_xy_route.sv
verilog/noc_inject_top.sv
test/tb_noc_inject_top.sv

//--- Makefile
TOP = tb_noc_inject_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the bench in SAM mode and in offset mode"
	@echo "  clean  remove the Verilator build folders"
	@echo "  help   show this list"

test:
	@for sam in 1 0; do \
	  echo "Running $(TOP) with UseSam=$$sam"; \
	  verilator --binary --assert --timescale 1ns/1ps -GUseSam=$$sam \
	    --top-module $(TOP) -f project.f -Mdir obj_dir_sam$$sam -o sim || exit 1; \
	  out=$$(./obj_dir_sam$$sam/sim 2>&1); \
	  echo "$$out"; \
	  echo "$$out" | grep -q "all tests passed" || exit 1; \
	done

clean:
	rm -rf obj_dir_sam1 obj_dir_sam0
